// ==== lite_regs_axi_pkg.sv ====
/*
 * AXI4-Lite bus definitions for the register file.
 * Holds the bus widths, the response codes, the channel structs and the
 * request and response bundles that travel between the bus and the slave.
 */
`default_nettype none

package lite_regs_axi_pkg;

  // Bus geometry, one beat carries a full chunk of four bytes
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Only the two codes this slave ever returns
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [2:0]            prot;
  } aw_chan_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [2:0]            prot;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    resp_e                 resp;
  } r_chan_t;

  // Master to slave bundle
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    ar_chan_t ar;
    logic     ar_valid;
    logic     b_ready;
    logic     r_ready;
  } req_t;

  // Slave to master bundle
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } rsp_t;

  // Recognizable pattern returned with every refused read
  localparam logic [DATA_WIDTH-1:0] ERR_RDATA = 32'hBAD0_BEEF;

endpackage

`default_nettype wire

// ==== lite_regs_cfg_pkg.sv ====
/*
 * Configuration of the register file.
 * Byte count, chunk geometry, the read-only mask, reset values and the
 * protection rule applied to every bus access.
 */
`default_nettype none

package lite_regs_cfg_pkg;

  // Twelve bytes form three chunks of one bus beat each
  localparam int NUM_BYTES  = 12;
  localparam int NUM_CHUNKS = 3;

  // Address bits looked at by the decoder, offsets 12 to 31 are unmapped
  localparam int OFFS_WIDTH = 5;

  typedef logic [1:0]                chunk_idx_t;
  typedef logic [7:0]                byte_t;
  typedef logic [NUM_BYTES-1:0]      byte_vec_t;
  typedef byte_t [NUM_BYTES-1:0]     byte_arr_t;

  // Byte 1 and the whole of chunk 2 are read-only from the bus
  localparam byte_vec_t READ_ONLY = 12'hF02;

  // Byte n comes out of reset as 0x10 plus n
  localparam byte_arr_t RST_VAL = {
    8'h1B, 8'h1A, 8'h19, 8'h18,
    8'h17, 8'h16, 8'h15, 8'h14,
    8'h13, 8'h12, 8'h11, 8'h10
  };

  // Accesses must carry the privileged bit, prot[0]
  localparam bit PRIV_ONLY = 1'b1;

endpackage

`default_nettype wire

// ==== lite_regs_wr_ctrl.sv ====
/*
 * Write stage of the register file.
 * Decodes the AW offset to a chunk, applies the privilege, range, read-only
 * and load-stall rules, and emits byte updates plus the B response code.
 */
`timescale 1ns/1ps
`default_nettype none

module lite_regs_wr_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  lite_regs_axi_pkg::aw_chan_t  aw_i,
  input  logic                         aw_valid_i,
  input  lite_regs_axi_pkg::w_chan_t   w_i,
  input  logic                         w_valid_i,
  input  lite_regs_cfg_pkg::byte_vec_t reg_load_i,
  input  logic                         b_space_i,
  output logic                         aw_ready_o,
  output logic                         w_ready_o,
  output logic                         b_push_o,
  output lite_regs_axi_pkg::b_chan_t   b_o,
  output lite_regs_cfg_pkg::byte_vec_t wr_upd_o,
  output lite_regs_cfg_pkg::byte_arr_t wr_data_o,
  output lite_regs_cfg_pkg::byte_vec_t wr_active_o
);

  logic [lite_regs_cfg_pkg::OFFS_WIDTH-1:0] offs;
  lite_regs_cfg_pkg::chunk_idx_t            chunk;
  lite_regs_cfg_pkg::byte_vec_t             strobed;
  logic                                     prot_ok;
  logic                                     in_range;
  logic                                     chunk_ro;
  logic                                     stall;
  logic                                     req_valid;

  // Upper address bits are ignored, only the low offset bits are decoded
  assign offs     = aw_i.addr[lite_regs_cfg_pkg::OFFS_WIDTH-1:0];
  // Bits 3:2 of the offset pick the four-byte chunk
  assign chunk    = offs[3:2];
  assign in_range = int'(offs) < lite_regs_cfg_pkg::NUM_BYTES;
  assign prot_ok  = aw_i.prot[0] || !lite_regs_cfg_pkg::PRIV_ONLY;

  // The B buffer must have room before both channels can be taken
  assign req_valid = aw_valid_i && w_valid_i && b_space_i;

  // Map the strobe lanes onto the bytes of the addressed chunk
  always_comb begin
    strobed  = '0;
    chunk_ro = 1'b0;
    for (int i = 0; i < lite_regs_cfg_pkg::NUM_BYTES; i++) begin
      wr_data_o[i] = w_i.data[8*(i % lite_regs_axi_pkg::STRB_WIDTH) +: 8];
      if (int'(chunk) == i / lite_regs_axi_pkg::STRB_WIDTH) begin
        strobed[i] = w_i.strb[i % lite_regs_axi_pkg::STRB_WIDTH];
      end
    end
    // A chunk made only of read-only bytes answers every write with SLVERR
    for (int c = 0; c < lite_regs_cfg_pkg::NUM_CHUNKS; c++) begin
      if (int'(chunk) == c) begin
        chunk_ro = &lite_regs_cfg_pkg::READ_ONLY[c*lite_regs_axi_pkg::STRB_WIDTH +:
                                                 lite_regs_axi_pkg::STRB_WIDTH];
      end
    end
  end

  // Hold off while logic loads a writable byte that this beat also strobes
  assign stall = |(strobed & ~lite_regs_cfg_pkg::READ_ONLY & reg_load_i);

  always_comb begin
    aw_ready_o  = 1'b0;
    w_ready_o   = 1'b0;
    b_push_o    = 1'b0;
    b_o.resp    = lite_regs_axi_pkg::RESP_SLVERR;
    wr_upd_o    = '0;
    wr_active_o = '0;
    if (req_valid) begin
      if (!prot_ok || !in_range) begin
        // Refused access is taken at once and touches no byte
        aw_ready_o = 1'b1;
        w_ready_o  = 1'b1;
        b_push_o   = 1'b1;
      end else if (!stall) begin
        aw_ready_o  = 1'b1;
        w_ready_o   = 1'b1;
        b_push_o    = 1'b1;
        wr_upd_o    = strobed & ~lite_regs_cfg_pkg::READ_ONLY;
        // Active flags also cover read-only bytes so logic can see the attempt
        wr_active_o = strobed;
        if (!chunk_ro) begin
          b_o.resp = lite_regs_axi_pkg::RESP_OKAY;
        end
      end
    end
  end

  // Any byte update must ride on an accepted beat and spare read-only bytes
  a_upd_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_upd_o != '0) |-> (b_push_o && ((wr_upd_o & lite_regs_cfg_pkg::READ_ONLY) == '0)));

endmodule

`default_nettype wire

// ==== lite_regs_rd_mux.sv ====
/*
 * Read stage of the register file.
 * Decodes the AR offset and gathers the chunk's four bytes into an R beat,
 * or returns the error pattern with SLVERR for a refused access.
 */
`timescale 1ns/1ps
`default_nettype none

module lite_regs_rd_mux (
  input  lite_regs_axi_pkg::ar_chan_t  ar_i,
  input  lite_regs_cfg_pkg::byte_arr_t reg_q_i,
  output lite_regs_axi_pkg::r_chan_t   r_o
);

  logic [lite_regs_cfg_pkg::OFFS_WIDTH-1:0] offs;
  lite_regs_cfg_pkg::chunk_idx_t            chunk;
  logic                                     access_ok;

  assign offs  = ar_i.addr[lite_regs_cfg_pkg::OFFS_WIDTH-1:0];
  assign chunk = offs[3:2];

  // Both the range and the privilege rule must pass for a real read
  assign access_ok = (int'(offs) < lite_regs_cfg_pkg::NUM_BYTES) &&
                     (ar_i.prot[0] || !lite_regs_cfg_pkg::PRIV_ONLY);

  always_comb begin
    r_o.data = lite_regs_axi_pkg::ERR_RDATA;
    r_o.resp = lite_regs_axi_pkg::RESP_SLVERR;
    if (access_ok) begin
      r_o.data = '0;
      r_o.resp = lite_regs_axi_pkg::RESP_OKAY;
      // Each byte of the chosen chunk lands on its own lane
      for (int i = 0; i < lite_regs_cfg_pkg::NUM_BYTES; i++) begin
        if (int'(chunk) == i / lite_regs_axi_pkg::STRB_WIDTH) begin
          r_o.data[8*(i % lite_regs_axi_pkg::STRB_WIDTH) +: 8] = reg_q_i[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== lite_regs_resp_buf.sv ====
/*
 * Two-entry response FIFO.
 * Registers B or R payloads so that no combinational path runs from the
 * request channels to the response channels, and keeps their order.
 */
`timescale 1ns/1ps
`default_nettype none

module lite_regs_resp_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     space_o,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       pop;

  // Space depends on state only, which keeps the ready path registered
  assign space_o = (count != 2'd2);
  assign valid_o = (count != 2'd0);
  assign pop     = valid_o && ready_i;
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push_i} - {1'b0, pop};
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // The producer stage has to respect the space flag
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> space_o);

  // A response offered under back-pressure must not change
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(data_o)));

endmodule

`default_nettype wire

// ==== lite_regs_array.sv ====
/*
 * Byte register array.
 * Twelve byte flops, each loaded either from logic or from a bus write,
 * with the logic load winning when both arrive together.
 */
`timescale 1ns/1ps
`default_nettype none

module lite_regs_array (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  lite_regs_cfg_pkg::byte_arr_t reg_d_i,
  input  lite_regs_cfg_pkg::byte_vec_t reg_load_i,
  input  lite_regs_cfg_pkg::byte_vec_t wr_upd_i,
  input  lite_regs_cfg_pkg::byte_arr_t wr_data_i,
  output lite_regs_cfg_pkg::byte_arr_t reg_q_o
);

  lite_regs_cfg_pkg::byte_arr_t reg_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_q <= lite_regs_cfg_pkg::RST_VAL;
    end else begin
      for (int i = 0; i < lite_regs_cfg_pkg::NUM_BYTES; i++) begin
        // Overlap only happens on bytes the bus is not allowed to change
        if (reg_load_i[i]) begin
          reg_q[i] <= reg_d_i[i];
        end else if (wr_upd_i[i]) begin
          reg_q[i] <= wr_data_i[i];
        end
      end
    end
  end

  assign reg_q_o = reg_q;

  // Read-only bytes may only move through a logic load
  for (genvar i = 0; i < lite_regs_cfg_pkg::NUM_BYTES; i++) begin : gen_ro_chk
    if (lite_regs_cfg_pkg::READ_ONLY[i]) begin : gen_ro
      a_ro_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !reg_load_i[i] |=> $stable(reg_q_o[i]));
    end
  end

endmodule

`default_nettype wire

// ==== lite_regs_top.sv ====
/*
 * AXI4-Lite register file top level.
 * Chains the write stage, the read stage, the byte array and one response
 * FIFO each for the B and R channels.
 */
`timescale 1ns/1ps
`default_nettype none

module lite_regs_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  lite_regs_axi_pkg::req_t      req_i,
  output lite_regs_axi_pkg::rsp_t      rsp_o,
  input  lite_regs_cfg_pkg::byte_arr_t reg_d_i,
  input  lite_regs_cfg_pkg::byte_vec_t reg_load_i,
  output lite_regs_cfg_pkg::byte_arr_t reg_q_o,
  output lite_regs_cfg_pkg::byte_vec_t wr_active_o
);

  logic                         aw_ready;
  logic                         w_ready;
  logic                         b_push;
  logic                         b_space;
  logic                         b_valid;
  lite_regs_axi_pkg::b_chan_t   b_in;
  lite_regs_axi_pkg::b_chan_t   b_out;
  logic                         r_push;
  logic                         r_space;
  logic                         r_valid;
  lite_regs_axi_pkg::r_chan_t   r_in;
  lite_regs_axi_pkg::r_chan_t   r_out;
  lite_regs_cfg_pkg::byte_vec_t wr_upd;
  lite_regs_cfg_pkg::byte_arr_t wr_data;

  lite_regs_wr_ctrl i_wr_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .aw_i        (req_i.aw),
    .aw_valid_i  (req_i.aw_valid),
    .w_i         (req_i.w),
    .w_valid_i   (req_i.w_valid),
    .reg_load_i  (reg_load_i),
    .b_space_i   (b_space),
    .aw_ready_o  (aw_ready),
    .w_ready_o   (w_ready),
    .b_push_o    (b_push),
    .b_o         (b_in),
    .wr_upd_o    (wr_upd),
    .wr_data_o   (wr_data),
    .wr_active_o (wr_active_o)
  );

  lite_regs_rd_mux i_rd_mux (
    .ar_i    (req_i.ar),
    .reg_q_i (reg_q_o),
    .r_o     (r_in)
  );

  lite_regs_array i_array (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .reg_d_i    (reg_d_i),
    .reg_load_i (reg_load_i),
    .wr_upd_i   (wr_upd),
    .wr_data_i  (wr_data),
    .reg_q_o    (reg_q_o)
  );

  lite_regs_resp_buf #(
    .payload_t (lite_regs_axi_pkg::b_chan_t)
  ) i_b_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (b_push),
    .data_i  (b_in),
    .space_o (b_space),
    .valid_o (b_valid),
    .ready_i (req_i.b_ready),
    .data_o  (b_out)
  );

  // An AR beat is pushed only in its handshake cycle
  assign r_push = req_i.ar_valid && r_space;

  lite_regs_resp_buf #(
    .payload_t (lite_regs_axi_pkg::r_chan_t)
  ) i_r_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (r_push),
    .data_i  (r_in),
    .space_o (r_space),
    .valid_o (r_valid),
    .ready_i (req_i.r_ready),
    .data_o  (r_out)
  );

  assign rsp_o = '{
    aw_ready: aw_ready,
    w_ready:  w_ready,
    b:        b_out,
    b_valid:  b_valid,
    ar_ready: r_space,
    r:        r_out,
    r_valid:  r_valid
  };

endmodule

`default_nettype wire

// ==== tb_lite_regs.sv ====
/*
 * Self-checking testbench for the AXI4-Lite register file.
 * Drives bus writes and reads, logic loads and back-pressure, and checks
 * every response against a byte model built from the register map rules.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_lite_regs;

  // About 80 bus operations at under 10 cycles each fit well inside this
  localparam int MAX_CYCLES = 2000;

  logic                         clk_i;
  logic                         rst_n_i;
  lite_regs_axi_pkg::req_t      req;
  lite_regs_axi_pkg::rsp_t      rsp;
  lite_regs_cfg_pkg::byte_arr_t reg_d;
  lite_regs_cfg_pkg::byte_vec_t reg_load;
  lite_regs_cfg_pkg::byte_arr_t reg_q;
  lite_regs_cfg_pkg::byte_vec_t wr_active;

  // Expected register contents and the responses still owed by the DUT
  logic [7:0]                   model [12];
  lite_regs_axi_pkg::resp_e     b_exp_q [$];
  logic [31:0]                  r_data_q [$];
  lite_regs_axi_pkg::resp_e     r_resp_q [$];
  lite_regs_cfg_pkg::byte_vec_t exp_act;

  int    errors = 0;
  int    checks = 0;
  int    cycle_cnt = 0;
  int    wait_cycles = 0;
  int    seed = 4527;
  string test_name = "reset";

  lite_regs_top i_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .rsp_o       (rsp),
    .reg_d_i     (reg_d),
    .reg_load_i  (reg_load),
    .reg_q_o     (reg_q),
    .wr_active_o (wr_active)
  );

  always #2 clk_i = ~clk_i;

  // Write-active flags may only show up together with a write handshake
  a_active_on_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_active != '0) |-> (rsp.aw_ready && rsp.w_ready))
  else begin
    errors++;
    $display("%s: wr_active_o raised without a write handshake", test_name);
  end

  // Handshake outputs must never float once reset is released
  a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({rsp.aw_ready, rsp.w_ready, rsp.ar_ready, rsp.b_valid, rsp.r_valid}))
  else begin
    errors++;
    $display("%s: unknown value on a handshake output", test_name);
  end

  function automatic bit byte_is_ro(input int idx);
    // Byte 1 and all of chunk 2 are read-only from the bus
    return (idx == 1) || (idx >= 8);
  endfunction

  task automatic check_val(input string label, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("[FAIL] %s/%s expected %h actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic check_array(input string label);
    for (int i = 0; i < 12; i++) begin
      check_val(label, 32'(model[i]), 32'(reg_q[i]));
    end
  endtask

  // Work out the B code, the active flags and the new byte values
  task automatic model_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [2:0] prot);
    int offs;
    int base;
    bit all_ro;
    offs    = int'(addr[4:0]);
    exp_act = '0;
    all_ro  = 1'b1;
    if (!prot[0] || offs >= 12) begin
      b_exp_q.push_back(lite_regs_axi_pkg::RESP_SLVERR);
    end else begin
      base = (offs / 4) * 4;
      for (int l = 0; l < 4; l++) begin
        all_ro &= byte_is_ro(base + l);
        if (strb[l]) begin
          exp_act[base+l] = 1'b1;
          if (!byte_is_ro(base + l)) begin
            model[base+l] = data[8*l +: 8];
          end
        end
      end
      b_exp_q.push_back(all_ro ? lite_regs_axi_pkg::RESP_SLVERR : lite_regs_axi_pkg::RESP_OKAY);
    end
  endtask

  task automatic model_read(input logic [7:0] addr, input logic [2:0] prot);
    int          offs;
    int          base;
    logic [31:0] data;
    offs = int'(addr[4:0]);
    if (!prot[0] || offs >= 12) begin
      r_data_q.push_back(lite_regs_axi_pkg::ERR_RDATA);
      r_resp_q.push_back(lite_regs_axi_pkg::RESP_SLVERR);
    end else begin
      base = (offs / 4) * 4;
      for (int l = 0; l < 4; l++) begin
        data[8*l +: 8] = model[base+l];
      end
      r_data_q.push_back(data);
      r_resp_q.push_back(lite_regs_axi_pkg::RESP_OKAY);
    end
  endtask

  task automatic drive_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [2:0] prot);
    @(negedge clk_i);
    req.aw.addr  = addr;
    req.aw.prot  = prot;
    req.w.data   = data;
    req.w.strb   = strb;
    req.aw_valid = 1'b1;
    req.w_valid  = 1'b1;
    model_write(addr, data, strb, prot);
  endtask

  // Sample mid low phase, the handshake then happens on the next rising edge
  task automatic accept_write();
    wait_cycles = 0;
    #1;
    while (!(rsp.aw_ready && rsp.w_ready)) begin
      @(negedge clk_i);
      #1;
      wait_cycles++;
    end
    check_val("wr_active", 32'(exp_act), 32'(wr_active));
    @(negedge clk_i);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
  endtask

  task automatic drive_read(input logic [7:0] addr, input logic [2:0] prot);
    @(negedge clk_i);
    req.ar.addr  = addr;
    req.ar.prot  = prot;
    req.ar_valid = 1'b1;
    model_read(addr, prot);
  endtask

  task automatic accept_read();
    #1;
    while (!rsp.ar_ready) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    req.ar_valid = 1'b0;
  endtask

  task automatic collect_b();
    lite_regs_axi_pkg::resp_e exp_resp;
    @(negedge clk_i);
    req.b_ready = 1'b1;
    #1;
    while (!rsp.b_valid) begin
      @(negedge clk_i);
      #1;
    end
    exp_resp = b_exp_q.pop_front();
    check_val("bresp", 32'(exp_resp), 32'(rsp.b.resp));
    @(negedge clk_i);
    req.b_ready = 1'b0;
  endtask

  task automatic collect_r();
    logic [31:0]              exp_data;
    lite_regs_axi_pkg::resp_e exp_resp;
    @(negedge clk_i);
    req.r_ready = 1'b1;
    #1;
    while (!rsp.r_valid) begin
      @(negedge clk_i);
      #1;
    end
    exp_data = r_data_q.pop_front();
    exp_resp = r_resp_q.pop_front();
    check_val("rdata", exp_data, rsp.r.data);
    check_val("rresp", 32'(exp_resp), 32'(rsp.r.resp));
    @(negedge clk_i);
    req.r_ready = 1'b0;
  endtask

  task automatic write(input logic [7:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input logic [2:0] prot);
    drive_write(addr, data, strb, prot);
    accept_write();
    // The B beat is registered, so it is up right after the accepting edge
    checks++;
    assert (rsp.b_valid) else begin
      errors++;
      $display("%s: no B response in the cycle after the write was accepted", test_name);
    end
    collect_b();
  endtask

  task automatic read(input logic [7:0] addr, input logic [2:0] prot);
    drive_read(addr, prot);
    accept_read();
    checks++;
    assert (rsp.r_valid) else begin
      errors++;
      $display("%s: no R response in the cycle after the read was accepted", test_name);
    end
    collect_r();
  endtask

  // The pending request must keep seeing ready low for a number of cycles
  task automatic expect_stall(input bit is_write, input int cycles);
    repeat (cycles) begin
      #1;
      checks++;
      if (is_write) begin
        assert (!rsp.aw_ready && !rsp.w_ready) else begin
          errors++;
          $display("%s: write was accepted although it had to wait", test_name);
        end
      end else begin
        assert (!rsp.ar_ready) else begin
          errors++;
          $display("%s: read was accepted although it had to wait", test_name);
        end
      end
      @(negedge clk_i);
    end
  endtask

  initial begin : watchdog
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] data;
    logic [7:0]  addr;
    int          offs;
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    req      = '0;
    reg_d    = '0;
    reg_load = '0;
    for (int i = 0; i < 12; i++) begin
      model[i] = 8'(16 + i);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Idle outputs and reset contents first, then plain reads of every chunk
    @(negedge clk_i);
    check_val("b_valid", 32'h0, 32'(rsp.b_valid));
    check_val("r_valid", 32'h0, 32'(rsp.r_valid));
    check_val("wr_active", 32'h0, 32'(wr_active));
    check_array("reg_q");
    for (int c = 0; c < 3; c++) begin
      read(8'(4 * c), 3'b001);
    end

    test_name = "rand_write";
    for (int k = 0; k < 12; k++) begin
      rnd  = $random(seed);
      data = $random(seed);
      addr = rnd[0] ? 8'h04 : 8'h00;
      write(addr, data, rnd[11:8], {rnd[14:13], 1'b1});
      read(addr, 3'b001);
    end
    check_val("byte1", 32'h11, 32'(reg_q[1]));

    test_name = "ro_chunk";
    write(8'h08, $random(seed), 4'hF, 3'b001);
    read(8'h08, 3'b001);

    test_name = "unpriv";
    write(8'h00, $random(seed), 4'hF, 3'b110);
    read(8'h04, 3'b000);
    check_array("reg_q");

    test_name = "out_of_range";
    for (int k = 0; k < 6; k++) begin
      rnd  = $random(seed);
      offs = 12 + int'({$random(seed)} % 20);
      addr = {rnd[2:0], 5'(offs)};
      write(addr, $random(seed), 4'hF, 3'b001);
      read(addr, 3'b001);
    end
    check_array("reg_q");

    // A load reaches a read-only byte that the bus can never write
    test_name = "load_ro";
    rnd = $random(seed);
    @(negedge clk_i);
    reg_d[9]    = rnd[7:0];
    reg_load[9] = 1'b1;
    model[9]    = rnd[7:0];
    @(negedge clk_i);
    reg_load[9] = 1'b0;
    check_val("byte9", 32'(rnd[7:0]), 32'(reg_q[9]));
    read(8'h08, 3'b001);

    test_name = "load_stall";
    @(negedge clk_i);
    reg_d[5]    = 8'hA5;
    reg_load[5] = 1'b1;
    model[5]    = 8'hA5;
    write(8'h04, $random(seed), 4'b0001, 3'b001);
    check_val("no_wait", 32'h0, 32'(wait_cycles));
    data = $random(seed);
    drive_write(8'h04, data, 4'b0010, 3'b001);
    expect_stall(1'b1, 4);
    reg_load[5] = 1'b0;
    accept_write();
    collect_b();
    check_val("byte5", 32'(data[15:8]), 32'(reg_q[5]));
    read(8'h04, 3'b001);

    // Two responses fit in each buffer, the third request has to wait
    test_name = "backpressure";
    drive_write(8'h00, $random(seed), 4'hF, 3'b001);
    accept_write();
    drive_write(8'h08, $random(seed), 4'hF, 3'b001);
    accept_write();
    drive_write(8'h04, $random(seed), 4'b0011, 3'b001);
    expect_stall(1'b1, 3);
    collect_b();
    accept_write();
    collect_b();
    collect_b();
    drive_read(8'h00, 3'b001);
    accept_read();
    drive_read(8'h08, 3'b001);
    accept_read();
    drive_read(8'h04, 3'b000);
    expect_stall(1'b0, 3);
    collect_r();
    accept_read();
    collect_r();
    collect_r();
    read(8'h04, 3'b001);
    check_array("reg_q");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== lite_regs.f ====
lite_regs_axi_pkg.sv
lite_regs_cfg_pkg.sv
lite_regs_wr_ctrl.sv
lite_regs_rd_mux.sv
lite_regs_resp_buf.sv
lite_regs_array.sv
lite_regs_top.sv
tb_lite_regs.sv

// ==== Makefile ====
TOP := tb_lite_regs

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f lite_regs.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

lint:
	verilator --lint-only --timing --assert -f lite_regs.f --top-module $(TOP)
	verilator --lint-only lite_regs_axi_pkg.sv lite_regs_cfg_pkg.sv lite_regs_wr_ctrl.sv \
		lite_regs_rd_mux.sv lite_regs_resp_buf.sv lite_regs_array.sv lite_regs_top.sv \
		--top-module lite_regs_top

clean:
	rm -rf obj_dir
